// File: vlog.f
source/arm_ctrl_pkg.sv
source/main_decoder.sv
source/alu_decoder.sv
source/cond_logic.sv
source/control_unit.sv
tb/control_unit_tb.sv

// File: run.sh
#!/bin/sh
# compile with verilator and run; exit status follows the testbench result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module control_unit_tb &&
./obj_dir/Vcontrol_unit_tb | tee /dev/stderr | grep -x "Everything OK" > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// File: tb/control_unit_tb.sv
////////////////////////////////////////////////////////////////////////////
// directed and random tests for the single-cycle ARM control unit
// inputs move on the falling edge, ctrl is sampled 1 ns before the rise
// the expected-value model tracks its own copy of the stored flags
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module control_unit_tb
    import arm_ctrl_pkg::*;
();

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 40;    // about 37 steps in the directed tests
    localparam int N_RANDOM        = 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + N_RANDOM + 150;

    logic      clk = 1'b0;
    logic      arst_n;
    instr_t    instr;
    nzcv_t     alu_flags;
    ctrl_out_t ctrl;

    nzcv_t     model_flags;     // expected stored nzcv
    int        errors;

    control_unit DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .instr     (instr),
        .alu_flags (alu_flags),
        .ctrl      (ctrl)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////
    // expected values
    ////////////////////////////////////////////////////////////////////////
    // arm table in pairs, odd codes invert the even one below them
    function automatic logic cond_holds(cond_t c, nzcv_t f);
        logic r;
        case (c[3:1])
            3'b000:  r = f.z;
            3'b001:  r = f.c;
            3'b010:  r = f.n;
            3'b011:  r = f.v;
            3'b100:  r = f.c & ~f.z;
            3'b101:  r = (f.n == f.v);
            3'b110:  r = ~f.z & (f.n == f.v);
            default: r = 1'b1;
        endcase
        if (c == 4'b1111) return 1'b0;
        if (c == 4'b1110) return 1'b1;      // AL
        return r ^ c[0];
    endfunction

    function automatic flag_w_t expected_flag_w(instr_t w);
        logic s;
        s = w[20];
        if (w[27:26] != OP_DP) return 2'b00;
        case (w[24:21])
            CMD_ADD, CMD_SUB, CMD_MOV: return {s, s};
            CMD_AND, CMD_ORR:          return {s, 1'b0};   // logic ops, n z only
            CMD_CMP:                   return 2'b11;
            default:                   return 2'b00;
        endcase
    endfunction

    function automatic ctrl_out_t expected_ctrl(instr_t w, nzcv_t f);
        ctrl_out_t e;
        logic      reg_w;
        logic      mem_w;
        logic      no_wr;
        logic      ex;
        e     = '0;
        reg_w = 1'b0;
        mem_w = 1'b0;
        no_wr = 1'b0;
        case (w[27:26])
            OP_DP: begin
                reg_w     = 1'b1;
                e.alu_src = w[25];          // I bit
                case (w[24:21])
                    CMD_SUB: e.alu_control = 2'b01;
                    CMD_AND: e.alu_control = 2'b10;
                    CMD_ORR: e.alu_control = 2'b11;
                    CMD_CMP: begin
                        e.alu_control = 2'b01;
                        no_wr         = 1'b1;
                    end
                    CMD_MOV: e.alu_src_a = 1'b1;
                    default: ;              // add and unknown cmds stay 00
                endcase
            end
            OP_MEM: begin
                e.alu_src = 1'b1;
                e.imm_src = 2'b01;
                if (w[20]) begin
                    e.mem_to_reg = 1'b1;
                    reg_w        = 1'b1;
                end else begin
                    mem_w     = 1'b1;
                    e.reg_src = 2'b10;
                end
            end
            OP_BR: begin
                e.alu_src = 1'b1;
                e.imm_src = 2'b10;
                e.reg_src = 2'b01;
            end
            default: ;                      // op 11 does nothing
        endcase
        ex          = cond_holds(w[31:28], f);
        e.reg_write = reg_w & ex & ~no_wr;
        e.mem_write = mem_w & ex;
        e.pc_src    = ((w[27:26] == OP_BR) | (reg_w & (w[15:12] == PC_REG))) & ex;
        return e;
    endfunction

    function automatic instr_t dp_word(cond_t c, logic i, logic [3:0] cmd, logic s,
                                       reg_addr_t rd);
        return {c, OP_DP, i, cmd, s, 4'h1, rd, 12'h005};
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // drive and check
    ////////////////////////////////////////////////////////////////////////
    task automatic check_bit(input logic got, input logic exp, input string what);
        assert (got === exp) else begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_pair(input logic [1:0] got, input logic [1:0] exp, input string what);
        assert (got === exp) else begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // one instruction per cycle, whole ctrl compared, model flags then follow the edge
    task automatic step(input instr_t w, input nzcv_t f);
        ctrl_out_t exp;
        flag_w_t   fw;
        @(negedge clk);
        instr     = w;
        alu_flags = f;
        exp       = expected_ctrl(w, model_flags);
        #(CLK_PERIOD / 2 - 1);              // just ahead of the rising edge
        assert (ctrl === exp) else begin
            $display("FAIL %0t: instr %h stored %b ctrl %b expected %b",
                     $time, w, model_flags, ctrl, exp);
            errors++;
        end
        fw = expected_flag_w(w);
        if (cond_holds(w[31:28], model_flags)) begin
            if (fw[1]) {model_flags.n, model_flags.z} = {f.n, f.z};
            if (fw[0]) {model_flags.c, model_flags.v} = {f.c, f.v};
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////
    task automatic test_reset_state();
        step(dp_word(COND_EQ, 1'b0, CMD_ADD, 1'b0, 4'd1), 4'b0000);
        check_bit(ctrl.reg_write, 1'b0, "EQ add after reset reg_write");
        step(dp_word(COND_NE, 1'b0, CMD_ADD, 1'b0, 4'd1), 4'b0000);
        check_bit(ctrl.reg_write, 1'b1, "NE add after reset reg_write");
    endtask

    task automatic test_dp_table();
        logic [3:0] cmds [6];
        int         k;
        cmds = '{CMD_ADD, CMD_SUB, CMD_AND, CMD_ORR, CMD_CMP, CMD_MOV};
        for (k = 0; k < 24; k++) begin
            step(dp_word(COND_AL, k[0], cmds[k / 4], k[1], 4'd2), 4'b0000);
            check_bit(ctrl.alu_src, k[0], "dp alu_src");
            check_bit(ctrl.reg_write, cmds[k / 4] != CMD_CMP, "dp reg_write");
        end
    endtask

    task automatic test_mem_branch();
        step({COND_AL, OP_MEM, 5'b01100, 1'b1, 4'h2, 4'd3, 12'h004}, 4'b0000);   // ldr
        check_bit(ctrl.mem_to_reg, 1'b1, "ldr mem_to_reg");
        check_bit(ctrl.mem_write, 1'b0, "ldr mem_write");
        check_pair(ctrl.imm_src, 2'b01, "ldr imm_src");
        step({COND_AL, OP_MEM, 5'b01100, 1'b0, 4'h2, 4'd3, 12'h004}, 4'b0000);   // str
        check_bit(ctrl.mem_write, 1'b1, "str mem_write");
        check_pair(ctrl.reg_src, 2'b10, "str reg_src");
        step({COND_AL, OP_BR, 2'b10, 24'h000010}, 4'b0000);                       // b
        check_bit(ctrl.pc_src, 1'b1, "b pc_src");
        check_pair(ctrl.imm_src, 2'b10, "b imm_src");
        check_pair(ctrl.reg_src, 2'b01, "b reg_src");
        step(dp_word(COND_AL, 1'b1, CMD_MOV, 1'b0, PC_REG), 4'b0000);
        check_bit(ctrl.pc_src, 1'b1, "mov to r15 pc_src");
    endtask

    task automatic test_flag_split();
        step(dp_word(COND_AL, 1'b0, CMD_CMP, 1'b1, 4'd0), 4'b0100);   // z set
        step(dp_word(COND_EQ, 1'b0, CMD_ADD, 1'b0, 4'd1), 4'b0000);
        check_bit(ctrl.reg_write, 1'b1, "EQ after cmp z=1 reg_write");
        step(dp_word(COND_AL, 1'b0, CMD_AND, 1'b1, 4'd1), 4'b0010);   // c offered, not taken
        step(dp_word(COND_CS, 1'b0, CMD_ADD, 1'b0, 4'd1), 4'b0000);
        check_bit(ctrl.reg_write, 1'b0, "CS after ands c=1 reg_write");
        step(dp_word(COND_AL, 1'b0, CMD_CMP, 1'b1, 4'd0), 4'b0100);
        step(dp_word(COND_NE, 1'b0, CMD_CMP, 1'b1, 4'd0), 4'b0000);   // false, no update
        step(dp_word(COND_EQ, 1'b0, CMD_ADD, 1'b0, 4'd1), 4'b0000);
        check_bit(ctrl.reg_write, 1'b1, "EQ after skipped cmp reg_write");
    endtask

    task automatic test_random();
        logic [31:0] rnd;
        int          k;
        for (k = 0; k < N_RANDOM; k++) begin
            rnd = $urandom;
            step($urandom, rnd[3:0]);       // every op and cond code reachable
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // run
    ////////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(70));
        instr       = '0;
        alu_flags   = '0;
        arst_n      = 1'b0;
        model_flags = '0;
        errors      = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_reset_state();
        test_dp_table();
        test_mem_branch();
        test_flag_split();
        test_random();
        @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

// File: source/control_unit.sv
////////////////////////////////////////////////////////////////////////////
// control unit top, single-cycle ARM subset
// all ctrl outputs are combinational from instr and the stored flags
// the one register is the nzcv copy inside the condition unit
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module control_unit
    import arm_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  instr_t    instr,
    input  nzcv_t     alu_flags,
    output ctrl_out_t ctrl
);

    // instruction fields
    cond_t     cond;
    op_t       op;
    funct_t    funct;
    reg_addr_t rd;

    // decoder results
    dec_ctrl_t dec_ctrl;
    alu_dec_t  alu_dec;
    logic      alu_op;

    // gated strobes
    logic      pc_src;
    logic      reg_write;
    logic      mem_write;

    assign cond  = instr[31:28];
    assign op    = instr[27:26];
    assign funct = instr[25:20];
    assign rd    = instr[15:12];

    ////////////////////////////////////////////////////////////////////////
    // decoders
    ////////////////////////////////////////////////////////////////////////
    main_decoder u_main_decoder (
        .op     (op),
        .funct  (funct),
        .rd     (rd),
        .dec    (dec_ctrl),
        .alu_op (alu_op)
    );

    alu_decoder u_alu_decoder (
        .funct  (funct[4:0]),   // I bit not needed here
        .alu_op (alu_op),
        .dec    (alu_dec)
    );

    ////////////////////////////////////////////////////////////////////////
    // condition unit
    ////////////////////////////////////////////////////////////////////////
    cond_logic u_cond_logic (
        .clk       (clk),
        .arst_n    (arst_n),
        .cond      (cond),
        .alu_flags (alu_flags),
        .flag_w    (alu_dec.flag_w),
        .pc_s      (dec_ctrl.pc_s),
        .reg_w     (dec_ctrl.reg_w),
        .mem_w     (dec_ctrl.mem_w),
        .no_write  (alu_dec.no_write),
        .pc_src    (pc_src),
        .reg_write (reg_write),
        .mem_write (mem_write)
    );

    // pack for the datapath, field order as in ctrl_out_t
    assign ctrl = '{
        pc_src      : pc_src,
        reg_write   : reg_write,
        mem_write   : mem_write,
        mem_to_reg  : dec_ctrl.mem_to_reg,
        alu_src     : dec_ctrl.alu_src,
        imm_src     : dec_ctrl.imm_src,
        reg_src     : dec_ctrl.reg_src,
        alu_control : alu_dec.alu_control,
        alu_src_a   : alu_dec.alu_src_a
    };

endmodule

// File: source/cond_logic.sv
////////////////////////////////////////////////////////////////////////////
// condition unit, stored nzcv plus cond field check
// condition is judged on the stored flags, new flags show up next edge
// flags clear to 0000 on arst_n, cond 1111 never executes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cond_logic
    import arm_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  cond_t   cond,
    input  nzcv_t   alu_flags,  // live from the alu
    input  flag_w_t flag_w,
    input  logic    pc_s,
    input  logic    reg_w,
    input  logic    mem_w,
    input  logic    no_write,
    output logic    pc_src,
    output logic    reg_write,
    output logic    mem_write
);

    nzcv_t flags;   // stored status
    logic  cond_ex; // instruction allowed to take effect
    logic  n_eq_v;  // signed compare helper

    assign n_eq_v = (flags.n == flags.v);

    ////////////////////////////////////////////////////////////////////////
    // condition check
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (cond)
            COND_EQ: cond_ex = flags.z;
            COND_NE: cond_ex = ~flags.z;
            COND_CS: cond_ex = flags.c;                 // unsigned >=
            COND_CC: cond_ex = ~flags.c;
            COND_MI: cond_ex = flags.n;
            COND_PL: cond_ex = ~flags.n;
            COND_VS: cond_ex = flags.v;
            COND_VC: cond_ex = ~flags.v;
            COND_HI: cond_ex = flags.c & ~flags.z;      // unsigned >
            COND_LS: cond_ex = ~flags.c | flags.z;
            COND_GE: cond_ex = n_eq_v;                  // signed >=
            COND_LT: cond_ex = ~n_eq_v;
            COND_GT: cond_ex = ~flags.z & n_eq_v;       // signed >
            COND_LE: cond_ex = flags.z | ~n_eq_v;
            COND_AL: cond_ex = 1'b1;
            default: cond_ex = 1'b0;                    // 1111, unused space
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // gated strobes
    ////////////////////////////////////////////////////////////////////////
    assign reg_write = reg_w & cond_ex & ~no_write;     // cmp never writes rd
    assign mem_write = mem_w & cond_ex;
    assign pc_src    = pc_s & cond_ex;

    ////////////////////////////////////////////////////////////////////////
    // flag register
    ////////////////////////////////////////////////////////////////////////
    // two halves with their own enables, logic ops leave c,v alone
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (cond_ex) begin
            if (flag_w[1]) begin
                flags.n <= alu_flags.n;
                flags.z <= alu_flags.z;
            end
            if (flag_w[0]) begin
                flags.c <= alu_flags.c;
                flags.v <= alu_flags.v;
            end
        end
    end

    // an unknown flag would poison every later conditional instruction
    a_flags_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(flags)
    ) else $error("cond_logic: stored flags unknown (%b)", flags);

endmodule

// File: source/alu_decoder.sv
////////////////////////////////////////////////////////////////////////////
// alu decoder, cmd and S to alu select and flag write enables
// only active for data processing (alu_op high)
// CMP always sets all flags and never writes back, whatever S says
// unlisted commands give all zeros
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module alu_decoder
    import arm_ctrl_pkg::*;
(
    input  logic [4:0] funct,   // {cmd, S}
    input  logic       alu_op,
    output alu_dec_t   dec
);

    logic [3:0] cmd;
    logic       s_bit;

    assign cmd   = funct[4:1];
    assign s_bit = funct[0];

    // cmd  | ctrl | flag_w S=0 / S=1 | extra
    // ADD  |  00  |   00 / 11        |
    // SUB  |  01  |   00 / 11        |
    // AND  |  10  |   00 / 10        | logic ops touch n,z only
    // ORR  |  11  |   00 / 10        |
    // CMP  |  01  |   11              | no_write
    // MOV  |  00  |   00 / 11        | alu_src_a
    always_comb begin
        dec = '0;

        if (alu_op) begin
            case (cmd)
                CMD_ADD: begin
                    dec.alu_control = 2'b00;
                    dec.flag_w      = {s_bit, s_bit};
                end
                CMD_SUB: begin
                    dec.alu_control = 2'b01;
                    dec.flag_w      = {s_bit, s_bit};
                end
                CMD_AND: begin
                    dec.alu_control = 2'b10;
                    dec.flag_w      = {s_bit, 1'b0};    // c,v untouched
                end
                CMD_ORR: begin
                    dec.alu_control = 2'b11;
                    dec.flag_w      = {s_bit, 1'b0};
                end
                CMD_CMP: begin
                    dec.alu_control = 2'b01;            // subtract, drop result
                    dec.flag_w      = 2'b11;
                    dec.no_write    = 1'b1;
                end
                CMD_MOV: begin
                    dec.alu_control = 2'b00;            // add with a forced
                    dec.flag_w      = {s_bit, s_bit};
                    dec.alu_src_a   = 1'b1;
                end
                default: begin
                    // outside the subset, stays zero
                end
            endcase
        end

        // a compare is pointless unless it lands in all four flags
        assert (!dec.no_write || (dec.flag_w == 2'b11))
            else $error("alu_decoder: no_write without full flag update, cmd=%b", cmd);
    end

endmodule

// File: source/main_decoder.sv
////////////////////////////////////////////////////////////////////////////
// main decoder, op/funct/rd to raw datapath controls
// outputs are ungated, the condition unit masks the write strobes
// op 11 decodes to all zeros
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module main_decoder
    import arm_ctrl_pkg::*;
(
    input  op_t       op,
    input  funct_t    funct,
    input  reg_addr_t rd,
    output dec_ctrl_t dec,
    output logic      alu_op
);

    logic is_imm;   // I bit
    logic is_load;  // L bit, shares position with S
    logic is_br;

    assign is_imm  = funct[5];
    assign is_load = funct[0];
    assign is_br   = (op == OP_BR);

    ////////////////////////////////////////////////////////////////////////
    // field decode
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        // defaults cover op 11 and keep every field driven
        dec    = '0;
        alu_op = 1'b0;

        case (op)
            OP_DP: begin
                dec.reg_w   = 1'b1;
                dec.alu_src = is_imm;       // reg or imm8 rotated
                dec.imm_src = 2'b00;
                alu_op      = 1'b1;         // alu decoder takes over
            end
            OP_MEM: begin
                dec.alu_src = 1'b1;         // base + imm12
                dec.imm_src = 2'b01;
                if (is_load) begin
                    dec.mem_to_reg = 1'b1;  // result from memory
                    dec.reg_w      = 1'b1;
                end else begin
                    dec.mem_w      = 1'b1;
                    dec.reg_src[1] = 1'b1;  // rd read as store data
                end
            end
            OP_BR: begin
                dec.alu_src    = 1'b1;      // pc+8 + imm24<<2
                dec.imm_src    = 2'b10;
                dec.reg_src[0] = 1'b1;      // r15 on port a
            end
            default: begin
                // op 11, nothing happens
            end
        endcase

        // pc written by a branch or by any register write to r15
        dec.pc_s = is_br | (dec.reg_w & (rd == PC_REG));

        // load and store share one op, they must stay exclusive
        assert (!(dec.reg_w && dec.mem_w))
            else $error("main_decoder: reg_w and mem_w both set, op=%b funct=%b",
                        op, funct);
    end

endmodule

// File: source/arm_ctrl_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types and codes for the single-cycle ARM control unit
// subset only: data processing (AND SUB ADD ORR CMP MOV), LDR/STR and B
// no shifts, no BL link, op 11 is treated as a no-op
////////////////////////////////////////////////////////////////////////////
package arm_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////////////////////////
    typedef logic [31:0] instr_t;       // whole instruction word
    typedef logic [3:0]  cond_t;        // bits 31:28
    typedef logic [1:0]  op_t;          // bits 27:26
    typedef logic [5:0]  funct_t;       // bits 25:20 -> {I, cmd[3:0], S}
    typedef logic [3:0]  reg_addr_t;    // register number, rd sits at 15:12

    // datapath select widths
    typedef logic [1:0]  alu_control_t; // 00 add, 01 sub, 10 and, 11 orr
    typedef logic [1:0]  flag_w_t;      // [1] updates n,z  [0] updates c,v
    typedef logic [1:0]  imm_src_t;     // 00 imm8, 01 imm12, 10 branch imm24

    // alu status flags, same order as the cpsr top nibble
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } nzcv_t;

    ////////////////////////////////////////////////////////////////////////
    // control bundles
    ////////////////////////////////////////////////////////////////////////
    // raw controls from the main decoder, not yet gated by cond
    typedef struct packed {
        logic       pc_s;
        logic       reg_w;
        logic       mem_w;
        logic       mem_to_reg;
        logic       alu_src;    // 1 selects extended immediate as alu b
        imm_src_t   imm_src;
        logic [1:0] reg_src;    // [1] rd as 2nd read port, [0] r15 as 1st
    } dec_ctrl_t;

    // alu decoder result
    typedef struct packed {
        alu_control_t alu_control;
        flag_w_t      flag_w;
        logic         no_write;  // compare only, result is dropped
        logic         alu_src_a; // mov path, a operand forced
    } alu_dec_t;

    // everything the datapath sees
    typedef struct packed {
        logic         pc_src;
        logic         reg_write;
        logic         mem_write;
        logic         mem_to_reg;
        logic         alu_src;
        imm_src_t     imm_src;
        logic [1:0]   reg_src;
        alu_control_t alu_control;
        logic         alu_src_a;
    } ctrl_out_t;

    ////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////
    localparam op_t OP_DP  = 2'b00;     // data processing
    localparam op_t OP_MEM = 2'b01;     // ldr / str
    localparam op_t OP_BR  = 2'b10;     // b

    // cmd field, funct[4:1]
    localparam logic [3:0] CMD_AND = 4'b0000;
    localparam logic [3:0] CMD_SUB = 4'b0010;
    localparam logic [3:0] CMD_ADD = 4'b0100;
    localparam logic [3:0] CMD_CMP = 4'b1010;
    localparam logic [3:0] CMD_ORR = 4'b1100;
    localparam logic [3:0] CMD_MOV = 4'b1101;

    // condition field, 4'b1111 left out on purpose (never executes here)
    localparam cond_t COND_EQ = 4'b0000;
    localparam cond_t COND_NE = 4'b0001;
    localparam cond_t COND_CS = 4'b0010;
    localparam cond_t COND_CC = 4'b0011;
    localparam cond_t COND_MI = 4'b0100;
    localparam cond_t COND_PL = 4'b0101;
    localparam cond_t COND_VS = 4'b0110;
    localparam cond_t COND_VC = 4'b0111;
    localparam cond_t COND_HI = 4'b1000;
    localparam cond_t COND_LS = 4'b1001;
    localparam cond_t COND_GE = 4'b1010;
    localparam cond_t COND_LT = 4'b1011;
    localparam cond_t COND_GT = 4'b1100;
    localparam cond_t COND_LE = 4'b1101;
    localparam cond_t COND_AL = 4'b1110;

    localparam reg_addr_t PC_REG = 4'd15;   // writes here redirect the pc

endpackage
